//--- compile.f
hw/uart_pkg.sv
hw/link_pkg.sv
hw/baud_gen.sv
hw/ack_uart_tx.sv
hw/tx_arbiter.sv
hw/link_tx_top.sv
dv/tb_link_tx_top.sv

//--- Makefile
TOP := tb_link_tx_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f compile.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- dv/tb_link_tx_top.sv
`timescale 1ns/1ps

module tb_link_tx_top
    import uart_pkg::*, link_pkg::*;
();

    localparam int FRAME_CLKS    = FRAME_BITS * BAUD_DIV;
    localparam int NUM_TRANSFERS = 60;
    localparam int FRAME_WAIT    = 2 * ACK_TIMEOUT + FRAME_CLKS;
    localparam int RESULT_LIMIT  = 2 * (MAX_RETRIES + 1) * (2 * FRAME_CLKS + ACK_TIMEOUT + 300);

    logic       clk;
    logic       reset;
    logic [1:0] req;
    logic [7:0] din [2];
    logic [1:0] done;
    logic [1:0] err;
    logic       tx_line;
    logic       ack_line;

    logic [31:0] lfsr = 32'hd085;
    int          transfers = 0;
    int          busy;
    int          first_done;

    // frames seen on tx_line since the last result
    logic [7:0] frame_byte [$];
    bit         frame_good [$];

    link_tx_top dut (
        .clk      (clk),
        .reset    (reset),
        .req_a    (req[0]),
        .data_a   (din[0]),
        .done_a   (done[0]),
        .error_a  (err[0]),
        .req_b    (req[1]),
        .data_b   (din[1]),
        .done_b   (done[1]),
        .error_b  (err[1]),
        .tx_line  (tx_line),
        .ack_line (ack_line)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // random source and failure exits
    ////////////////////////////////////////

    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = next_lfsr(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic end_failed();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic mismatch_stop(input string name, input int exp_val, input int act_val);
        $display("** Error [%s] expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
        end_failed();
    endtask

    task automatic halt_with(input string what);
        $display("%s", what);
        end_failed();
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (tx_line === LINE_IDLE)
                else mismatch_stop("idle tx_line", int'(LINE_IDLE), int'(tx_line));
            assert ((done | err) === 2'b00)
                else mismatch_stop("idle result pulses", 0, int'(done | err));
        end
    endtask

    ////////////////////////////////////////
    // client side and reference model
    ////////////////////////////////////////

    task automatic run_client(input int id, input logic [7:0] value, input int gap,
                              input bit other_idle);
        int waited;
        int first_good;
        int exp_frames;
        bit exp_done;
        repeat (gap) begin
            @(negedge clk);
        end
        din[id] = value;
        req[id] = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (other_idle) begin
                assert (done[1-id] === 1'b0 && err[1-id] === 1'b0)
                    else mismatch_stop("idle client pulse", 0, int'({done[1-id], err[1-id]}));
            end
            if (waited > RESULT_LIMIT) begin
                halt_with("client saw neither done nor error before the timeout");
            end
        end while (done[id] !== 1'b1 && err[id] !== 1'b1);

        if (first_done < 0) begin
            first_done = id;
        end
        // done on the first correct echo within MAX_RETRIES+1 frames
        first_good = -1;
        foreach (frame_good[i]) begin
            if (frame_good[i] && first_good < 0) begin
                first_good = i;
            end
        end
        exp_done   = (first_good >= 0) && (first_good <= MAX_RETRIES);
        exp_frames = exp_done ? first_good + 1 : MAX_RETRIES + 1;
        assert (!(done[id] && err[id])) else halt_with("done and error pulsed together");
        assert (done[id] === exp_done)
            else mismatch_stop("result kind", int'(exp_done), int'(done[id]));
        assert (frame_byte.size() == exp_frames)
            else mismatch_stop("frame count", exp_frames, frame_byte.size());
        foreach (frame_byte[i]) begin
            assert (frame_byte[i] == value)
                else mismatch_stop("frame byte", int'(value), int'(frame_byte[i]));
        end
        frame_byte.delete();
        frame_good.delete();
        transfers++;
        req[id] = 1'b0;
        busy--;

        // one pulse per request
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            assert (done[id] === 1'b0 && err[id] === 1'b0)
                else mismatch_stop("single result pulse", 0, int'({done[id], err[id]}));
            if (waited > RESULT_LIMIT) begin
                halt_with("other client did not finish before the timeout");
            end
        end while (busy != 0);
    endtask

    ////////////////////////////////////////
    // line responder
    ////////////////////////////////////////

    task automatic send_ack(input logic [7:0] value);
        logic [8:0] bits;
        bits = {value, 1'b0};
        for (int k = 0; k < 9; k++) begin
            ack_line = bits[k];
            repeat (BAUD_DIV) @(negedge clk);
        end
        // stop bit runs into idle
        ack_line = LINE_IDLE;
    endtask

    initial begin : line_responder
        logic [FRAME_CLKS-1:0] samp;
        logic [7:0]            rx;
        logic [7:0]            reply;
        logic [1:0]            choice;
        logic [2:0]            flip_pos;
        logic                  expect_bit;
        int                    idle;
        int                    delay;
        int                    slot;
        ack_line = LINE_IDLE;
        forever begin
            idle = 0;
            do begin
                @(negedge clk);
                idle++;
                if (idle > FRAME_WAIT) begin
                    halt_with("no frame started on tx_line before the timeout");
                end
            end while (tx_line !== 1'b0);

            // one sample per clock, first one half a clock after the start edge
            for (int n = 0; n < FRAME_CLKS; n++) begin
                if (n > 0) begin
                    @(negedge clk);
                end
                samp[n] = tx_line;
            end
            for (int k = 0; k < DATA_BITS; k++) begin
                rx[k] = samp[(k + 1) * BAUD_DIV + HALF_BAUD];
            end
            for (int n = 0; n < FRAME_CLKS; n++) begin
                slot = n / BAUD_DIV;
                if (slot == 0) begin
                    expect_bit = 1'b0;
                end else if (slot == FRAME_BITS - 1) begin
                    expect_bit = 1'b1;
                end else begin
                    expect_bit = rx[slot - 1];
                end
                assert (samp[n] === expect_bit)
                    else mismatch_stop("frame bit timing", int'(expect_bit), int'(samp[n]));
            end

            // echo, corrupted echo or silence
            choice = 2'(take_bits(2));
            delay  = int'(take_bits(8));
            frame_byte.push_back(rx);
            frame_good.push_back(choice < 2'd2);
            if (choice != 2'd3) begin
                reply = rx;
                if (choice == 2'd2) begin
                    flip_pos        = 3'(take_bits(3));
                    reply[flip_pos] = ~reply[flip_pos];
                end
                repeat (delay + 1) @(negedge clk);
                send_ack(reply);
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : main_seq
        logic [1:0] want;
        logic [7:0] byte_a;
        logic [7:0] byte_b;
        int         gap_a;
        int         gap_b;
        int         winner;
        bit         last_b;
        reset  = 1'b1;
        req    = 2'b00;
        din[0] = 8'h00;
        din[1] = 8'h00;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_idle(20);

        // b counts as served last, so a wins first
        last_b = 1'b1;
        while (transfers < NUM_TRANSFERS) begin
            want = 2'(take_bits(2));
            if (want == 2'd0) begin
                want = 2'd3;
            end
            byte_a = 8'(take_bits(8));
            byte_b = 8'(take_bits(8));
            gap_a  = int'(take_bits(2));
            gap_b  = int'(take_bits(2));
            first_done = -1;
            busy       = (want == 2'd3) ? 2 : 1;
            if (want == 2'd3) begin
                // earlier request wins, a tie goes round robin
                if (gap_a != gap_b) begin
                    winner = (gap_a < gap_b) ? 0 : 1;
                end else begin
                    winner = last_b ? 0 : 1;
                end
            end else begin
                winner = want[0] ? 0 : 1;
            end
            fork
                if (want[0]) begin
                    run_client(0, byte_a, gap_a, !want[1]);
                end
                if (want[1]) begin
                    run_client(1, byte_b, gap_b, !want[0]);
                end
            join
            assert (first_done == winner) else mismatch_stop("service order", winner, first_done);
            last_b = (want == 2'd3) ? (winner == 0) : want[1];
            check_idle(1 + int'(take_bits(3)));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- hw/link_tx_top.sv
`timescale 1ns/1ps

module link_tx_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       req_a,
    input  logic [7:0] data_a,
    output logic       done_a,
    output logic       error_a,
    input  logic       req_b,
    input  logic [7:0] data_b,
    output logic       done_b,
    output logic       error_b,
    output logic       tx_line,
    input  logic       ack_line
);

    logic       start;
    logic [7:0] tx_data;
    logic       ok;
    logic       fail;
    logic       restart;
    logic       tick;

    tx_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .req_a   (req_a),
        .req_b   (req_b),
        .data_a  (data_a),
        .data_b  (data_b),
        .ok      (ok),
        .fail    (fail),
        .start   (start),
        .tx_data (tx_data),
        .done_a  (done_a),
        .error_a (error_a),
        .done_b  (done_b),
        .error_b (error_b)
    );

    // bit timing restarts with every frame
    baud_gen u_baud (
        .clk     (clk),
        .reset   (reset),
        .restart (restart),
        .tick    (tick)
    );

    ack_uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .tx_data  (tx_data),
        .tick     (tick),
        .ack_line (ack_line),
        .restart  (restart),
        .tx_line  (tx_line),
        .ok       (ok),
        .fail     (fail)
    );

endmodule

//--- hw/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_a,
    input  logic       req_b,
    input  logic [7:0] data_a,
    input  logic [7:0] data_b,
    input  logic       ok,
    input  logic       fail,
    output logic       start,
    output logic [7:0] tx_data,
    output logic       done_a,
    output logic       error_a,
    output logic       done_b,
    output logic       error_b
);

    // one-hot owner, bit 0 is client a
    logic [NUM_CLIENTS-1:0] grant;
    logic [NUM_CLIENTS-1:0] pick;
    logic                   last_served;
    logic                   elig_a;
    logic                   elig_b;
    logic                   grant_now;

    // a client still seeing its result pulse holds the old request
    assign elig_a = req_a && !done_a && !error_a;
    assign elig_b = req_b && !done_b && !error_b;

    always_comb begin
        pick = '0;
        if (elig_a && (!elig_b || last_served)) begin
            pick[0] = 1'b1;
        end else if (elig_b) begin
            pick[1] = 1'b1;
        end
    end

    assign grant_now = !(|grant) && (|pick);

    always_ff @(posedge clk) begin
        if (reset) begin
            grant       <= '0;
            last_served <= 1'b1;
            start       <= 1'b0;
            done_a      <= 1'b0;
            error_a     <= 1'b0;
            done_b      <= 1'b0;
            error_b     <= 1'b0;
        end else begin
            start   <= 1'b0;
            done_a  <= ok && grant[0];
            error_a <= fail && grant[0];
            done_b  <= ok && grant[1];
            error_b <= fail && grant[1];
            if ((|grant) && (ok || fail)) begin
                grant <= '0;
            end else if (grant_now) begin
                grant       <= pick;
                last_served <= pick[1];
                start       <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_now) begin
            tx_data <= pick[0] ? data_a : data_b;
        end
    end

endmodule

//--- hw/ack_uart_tx.sv
`timescale 1ns/1ps

module ack_uart_tx
    import uart_pkg::*, link_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic                 tick,
    input  logic                 ack_line,
    output logic                 restart,
    output logic                 tx_line,
    output logic                 ok,
    output logic                 fail
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP,
        ST_WAIT_ACK,
        ST_READ_ACK
    } state_t;

    state_t state;

    logic [DATA_BITS-1:0]  tx_buf;
    logic [DATA_BITS-1:0]  ack_buf;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [TIMEOUT_W-1:0]  ack_timer;
    logic [BAUD_CNT_W-1:0] samp_cnt;
    logic [PHASE_W-1:0]    ack_phase;
    logic [RETRY_W-1:0]    retry_cnt;
    logic                  resend;

    logic launch;
    logic sample;
    logic last_sample;
    logic ack_timeout;
    logic echo_good;
    logic frame_bad;

    // new frame: first attempt or a pending resend
    assign launch  = (state == ST_IDLE) && (start || resend);
    assign restart = launch;

    assign sample      = (state == ST_READ_ACK) && (samp_cnt == '0);
    assign last_sample = sample && (ack_phase == PHASE_W'(FRAME_BITS - 1));
    assign ack_timeout = (state == ST_WAIT_ACK) && ack_line
                         && (ack_timer == TIMEOUT_W'(ACK_TIMEOUT - 1));

    // ack stop bit must be high and the byte must echo what went out
    assign echo_good = last_sample && ack_line && (ack_buf == tx_buf);
    assign frame_bad = ack_timeout
                       || (last_sample && !(ack_line && (ack_buf == tx_buf)));

    ////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            tx_line   <= LINE_IDLE;
            bit_cnt   <= '0;
            ack_timer <= '0;
            samp_cnt  <= '0;
            ack_phase <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (launch) begin
                        tx_line <= ~LINE_IDLE;
                        state   <= ST_START;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        tx_line <= tx_buf[0];
                        bit_cnt <= '0;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (tick) begin
                        if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
                            tx_line <= LINE_IDLE;
                            state   <= ST_STOP;
                        end else begin
                            // lsb first
                            tx_line <= tx_buf[bit_cnt + 1'b1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_STOP: begin
                    if (tick) begin
                        ack_timer <= '0;
                        state     <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (!ack_line) begin
                        samp_cnt  <= BAUD_CNT_W'(HALF_BAUD - 1);
                        ack_phase <= '0;
                        state     <= ST_READ_ACK;
                    end else if (ack_timeout) begin
                        state <= ST_IDLE;
                    end else begin
                        ack_timer <= ack_timer + 1'b1;
                    end
                end
                ST_READ_ACK: begin
                    if (sample) begin
                        samp_cnt  <= BAUD_CNT_W'(BAUD_DIV - 1);
                        ack_phase <= ack_phase + 1'b1;
                        if (ack_phase == '0 && ack_line) begin
                            // glitch, not a start bit
                            state <= ST_WAIT_ACK;
                        end else if (last_sample) begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        samp_cnt <= samp_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // byte held for all retries
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            tx_buf <= tx_data;
        end
    end

    // ack data bits shift in lsb first
    always_ff @(posedge clk) begin
        if (sample && ack_phase != '0 && ack_phase <= PHASE_W'(DATA_BITS)) begin
            ack_buf <= {ack_line, ack_buf[DATA_BITS-1:1]};
        end
    end

    ////////////////////////////////////////
    // result and retry count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            retry_cnt <= '0;
            resend    <= 1'b0;
            ok        <= 1'b0;
            fail      <= 1'b0;
        end else begin
            ok     <= 1'b0;
            fail   <= 1'b0;
            resend <= 1'b0;
            if (echo_good) begin
                ok        <= 1'b1;
                retry_cnt <= '0;
            end else if (frame_bad) begin
                if (retry_cnt == RETRY_W'(MAX_RETRIES)) begin
                    fail      <= 1'b1;
                    retry_cnt <= '0;
                end else begin
                    retry_cnt <= retry_cnt + 1'b1;
                    resend    <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/baud_gen.sv
`timescale 1ns/1ps

module baud_gen
    import uart_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic restart,
    output logic tick
);

    logic [BAUD_CNT_W-1:0] count;

    // reload on restart so the first tick lands BAUD_DIV clocks later
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            count <= BAUD_CNT_W'(BAUD_DIV - 1);
        end else if (count == '0) begin
            count <= BAUD_CNT_W'(BAUD_DIV - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    assign tick = (count == '0);

endmodule

//--- hw/link_pkg.sv
package link_pkg;
    import uart_pkg::*;

    ////////////////////////////////////////
    // acknowledge and retry
    ////////////////////////////////////////

    // clocks to wait for an ack start edge after the stop bit
    localparam int ACK_TIMEOUT = 24 * BAUD_DIV;
    localparam int TIMEOUT_W   = $clog2(ACK_TIMEOUT);

    // resends after the first attempt
    localparam int MAX_RETRIES = 3;
    localparam int RETRY_W     = $clog2(MAX_RETRIES + 1);

    ////////////////////////////////////////
    // clients
    ////////////////////////////////////////

    localparam int NUM_CLIENTS = 2;

endpackage

//--- hw/uart_pkg.sv
package uart_pkg;

    ////////////////////////////////////////
    // serial line timing
    ////////////////////////////////////////

    // clocks per bit, kept small for simulation
    localparam int BAUD_DIV = 16;

    // start edge to mid-bit
    localparam int HALF_BAUD = BAUD_DIV / 2;

    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

    ////////////////////////////////////////
    // frame layout
    ////////////////////////////////////////

    localparam int DATA_BITS = 8;
    localparam int BIT_CNT_W = $clog2(DATA_BITS);

    // start + data + stop
    localparam int FRAME_BITS = DATA_BITS + 2;
    localparam int PHASE_W    = $clog2(FRAME_BITS);

    // idle level of tx and ack lines
    localparam logic LINE_IDLE = 1'b1;

endpackage
